// File: source/net_ctrl_pkg.sv
// shared types and constants for the link connection controller
// state encodings, generator/sniffer status and command bundles,
// and the simulation-sized wait times used by the qualifiers and timer
`default_nettype none

package net_ctrl_pkg;

    // ------------------------------
    // wait constants (cycles of clk_PP)
    // ------------------------------
    // hardware values are near 2^26 for the link and 1000 for the message
    localparam int LINK_WAIT  = 16;
    localparam int MSG_WAIT   = 8;
    localparam int LOST_LIMIT = 64;
    // wide enough to hold LOST_LIMIT itself
    localparam int LOST_BITS  = $clog2(LOST_LIMIT + 1);

    // ------------------------------
    // state encodings
    // ------------------------------
    // connection state, initiator side
    typedef enum logic [2:0] {
        DISCONNECT    = 3'd0,
        HANDSHAKE_SYN = 3'd1,
        HANDSHAKE_ACK = 3'd2,
        TRANSFER      = 3'd3,
        ACK_SEND      = 3'd4
    } tcp_state_e;

    // transfer sequencer, gray-ish codes
    typedef enum logic [2:0] {
        IDLE           = 3'b000,
        SEND           = 3'b001,
        WAIT_TX        = 3'b011,
        WAIT_RX        = 3'b010,
        WAIT_ACK_CHECK = 3'b111,
        WAIT_TX_ACK    = 3'b100,
        WAIT_RX_LAST   = 3'b101
    } xfer_state_e;

    // ------------------------------
    // status and command bundles
    // ------------------------------
    // from the frame generator
    typedef struct packed {
        logic busy;
        logic msg_pending;
        logic ack_taken;
    } tx_status_t;

    // from the frame sniffer, received_valid is a one-cycle pulse
    typedef struct packed {
        logic busy;
        logic received_valid;
        logic is_handshake;
        logic need_ack;
    } rx_status_t;

    // to generator and sniffer
    typedef struct packed {
        logic transfer_en;
        logic block_tx;
        logic block_rx;
        logic ack_received;
    } path_ctrl_t;

endpackage

`default_nettype wire

// File: source/level_qualifier.sv
// hold-time qualifier for a slow status level
// level_ok goes high once level_in has stayed high for HOLD_CYCLES+1 edges
// and drops again shortly after level_in goes low
`default_nettype none

module level_qualifier #(
    parameter int HOLD_CYCLES = 16
) (
    input  wire  clk_PP,
    input  wire  reset,
    input  logic level_in,
    output logic level_ok
);

    localparam int CNT_BITS = $clog2(HOLD_CYCLES + 1);

    logic [CNT_BITS-1:0] hold_cnt;

    // count up while high, stick at the limit, restart on any low sample
    always_ff @(posedge clk_PP or posedge reset) begin
        if (reset) begin
            hold_cnt <= '0;
        end else if (!level_in) begin
            hold_cnt <= '0;
        end else if (hold_cnt != CNT_BITS'(HOLD_CYCLES)) begin
            hold_cnt <= hold_cnt + 1'b1;
        end
    end

    // registered compare, one edge behind the counter
    always_ff @(posedge clk_PP or posedge reset) begin
        if (reset) begin
            level_ok <= 1'b0;
        end else begin
            level_ok <= (hold_cnt == CNT_BITS'(HOLD_CYCLES));
        end
    end

endmodule

`default_nettype wire

// File: source/tcp_conn_fsm.sv
// connection state machine, initiator role
// brings the connection up after the link qualifies and then moves
// between transfer, ack sending and handshake repeats; only reset disconnects
`default_nettype none

module tcp_conn_fsm (
    input  wire                       clk_PP,
    input  wire                       reset,
    input  logic                      link_up,
    input  net_ctrl_pkg::rx_status_t  rx_status,
    input  logic                      send_done,
    output net_ctrl_pkg::tcp_state_e  tcp_state
);

    net_ctrl_pkg::tcp_state_e state_next;

    // ------------------------------
    // state register
    // ------------------------------
    always_ff @(posedge clk_PP or posedge reset) begin
        if (reset) begin
            tcp_state <= net_ctrl_pkg::DISCONNECT;
        end else begin
            tcp_state <= state_next;
        end
    end

    // ------------------------------
    // next state
    // ------------------------------
    always_comb begin
        state_next = tcp_state;
        case (tcp_state)
            net_ctrl_pkg::DISCONNECT: begin
                // initiator opens as soon as the link is stable
                if (link_up) begin
                    state_next = net_ctrl_pkg::HANDSHAKE_SYN;
                end
            end
            net_ctrl_pkg::HANDSHAKE_SYN: begin
                // peer answered the opening frame
                if (rx_status.received_valid && rx_status.is_handshake) begin
                    state_next = net_ctrl_pkg::HANDSHAKE_ACK;
                end
            end
            net_ctrl_pkg::HANDSHAKE_ACK: begin
                if (send_done) begin
                    state_next = net_ctrl_pkg::TRANSFER;
                end
            end
            net_ctrl_pkg::TRANSFER: begin
                // handshake frame wins over an ack request
                if (rx_status.received_valid) begin
                    if (rx_status.is_handshake) begin
                        state_next = net_ctrl_pkg::HANDSHAKE_ACK;
                    end else if (rx_status.need_ack) begin
                        state_next = net_ctrl_pkg::ACK_SEND;
                    end
                end
            end
            net_ctrl_pkg::ACK_SEND: begin
                if (send_done) begin
                    state_next = net_ctrl_pkg::TRANSFER;
                end
            end
            default: begin
                state_next = net_ctrl_pkg::DISCONNECT;
            end
        endcase
    end

endmodule

`default_nettype wire

// File: source/transfer_seq.sv
// transfer sequencer below the connection state machine
// issues the send strobe, holds the tx/rx block levels, reports send_done
// and echoes each received frame back to the generator as ack_received
`default_nettype none

module transfer_seq (
    input  wire                       clk_PP,
    input  wire                       reset,
    input  net_ctrl_pkg::tcp_state_e  tcp_state,
    input  net_ctrl_pkg::tx_status_t  tx_status,
    input  net_ctrl_pkg::rx_status_t  rx_status,
    input  logic                      timed_out,
    output net_ctrl_pkg::path_ctrl_t  ctrl,
    output logic                      send_done,
    output logic                      waiting
);

    net_ctrl_pkg::xfer_state_e state;
    net_ctrl_pkg::xfer_state_e state_next;
    logic                      transfer_en_q;
    logic                      ack_received_q;

    // ------------------------------
    // registers
    // ------------------------------
    always_ff @(posedge clk_PP or posedge reset) begin
        if (reset) begin
            state          <= net_ctrl_pkg::IDLE;
            transfer_en_q  <= 1'b0;
            ack_received_q <= 1'b0;
        end else begin
            state          <= state_next;
            // one strobe cycle per cycle spent in SEND
            transfer_en_q  <= (state == net_ctrl_pkg::SEND);
            ack_received_q <= rx_status.received_valid;
        end
    end

    // ------------------------------
    // next state
    // ------------------------------
    always_comb begin
        state_next = state;
        if (tcp_state == net_ctrl_pkg::DISCONNECT) begin
            state_next = net_ctrl_pkg::IDLE;
        end else begin
            case (state)
                net_ctrl_pkg::IDLE: begin
                    // data frames only go out when a message is queued
                    if (!tx_status.busy) begin
                        if (tcp_state != net_ctrl_pkg::TRANSFER || tx_status.msg_pending) begin
                            state_next = net_ctrl_pkg::SEND;
                        end
                    end
                end
                net_ctrl_pkg::SEND: begin
                    if (tcp_state == net_ctrl_pkg::TRANSFER && !tx_status.msg_pending) begin
                        state_next = net_ctrl_pkg::IDLE;
                    end else if (tx_status.busy) begin
                        state_next = net_ctrl_pkg::WAIT_TX;
                    end
                end
                net_ctrl_pkg::WAIT_TX: begin
                    // syn and data expect a reply, the rest do not
                    if (!tx_status.busy) begin
                        if (tcp_state == net_ctrl_pkg::HANDSHAKE_SYN ||
                            tcp_state == net_ctrl_pkg::TRANSFER) begin
                            state_next = net_ctrl_pkg::WAIT_RX;
                        end else begin
                            state_next = net_ctrl_pkg::IDLE;
                        end
                    end
                end
                net_ctrl_pkg::WAIT_RX: begin
                    // no reply in time, resend
                    if (rx_status.busy) begin
                        state_next = net_ctrl_pkg::WAIT_ACK_CHECK;
                    end else if (timed_out) begin
                        state_next = net_ctrl_pkg::SEND;
                    end
                end
                net_ctrl_pkg::WAIT_ACK_CHECK: begin
                    if (rx_status.received_valid) begin
                        if (!rx_status.is_handshake && !rx_status.need_ack &&
                            tx_status.msg_pending) begin
                            state_next = net_ctrl_pkg::WAIT_TX_ACK;
                        end else begin
                            state_next = net_ctrl_pkg::WAIT_RX_LAST;
                        end
                    end else if (!rx_status.busy) begin
                        // frame dropped by the sniffer
                        state_next = net_ctrl_pkg::IDLE;
                    end
                end
                net_ctrl_pkg::WAIT_TX_ACK: begin
                    if (tx_status.ack_taken) begin
                        state_next = net_ctrl_pkg::WAIT_RX_LAST;
                    end
                end
                net_ctrl_pkg::WAIT_RX_LAST: begin
                    if (!rx_status.busy) begin
                        state_next = net_ctrl_pkg::IDLE;
                    end
                end
                default: begin
                    state_next = net_ctrl_pkg::IDLE;
                end
            endcase
        end
    end

    // ------------------------------
    // output decode
    // ------------------------------
    assign send_done = (state == net_ctrl_pkg::WAIT_TX) && !tx_status.busy;
    assign waiting   = (state == net_ctrl_pkg::WAIT_RX);

    always_comb begin
        ctrl.transfer_en  = transfer_en_q;
        // generator held off whenever we are listening or idle
        ctrl.block_tx     = (state == net_ctrl_pkg::IDLE) ||
                            (state == net_ctrl_pkg::WAIT_RX) ||
                            (state == net_ctrl_pkg::WAIT_RX_LAST);
        // sniffer held off while our own frame goes out
        ctrl.block_rx     = (state == net_ctrl_pkg::SEND) ||
                            (state == net_ctrl_pkg::WAIT_TX);
        ctrl.ack_received = ack_received_q;
    end

endmodule

`default_nettype wire

// File: source/response_timer.sv
// reply timeout counter
// counts while the sequencer waits for the peer and flags timed_out
// once LOST_LIMIT cycles have passed; clears as soon as waiting drops
`default_nettype none

module response_timer (
    input  wire  clk_PP,
    input  wire  reset,
    input  logic waiting,
    output logic timed_out
);

    localparam logic [net_ctrl_pkg::LOST_BITS-1:0] LIMIT =
        net_ctrl_pkg::LOST_BITS'(net_ctrl_pkg::LOST_LIMIT);

    logic [net_ctrl_pkg::LOST_BITS-1:0] lost_cnt;

    // saturating count, zero outside the wait
    always_ff @(posedge clk_PP or posedge reset) begin
        if (reset) begin
            lost_cnt <= '0;
        end else if (!waiting) begin
            lost_cnt <= '0;
        end else if (lost_cnt != LIMIT) begin
            lost_cnt <= lost_cnt + 1'b1;
        end
    end

    // stays high until the sequencer leaves WAIT_RX
    assign timed_out = (lost_cnt == LIMIT);

endmodule

`default_nettype wire

// File: source/net_ctrl_top.sv
// top level of the connection controller
// qualifies link and message levels, runs the connection FSM and the
// transfer sequencer, and drives the generator/sniffer command bundle
`default_nettype none

module net_ctrl_top (
    input  wire                       clk_PP,
    input  wire                       reset,
    input  logic                      link_status,
    input  logic                      msg_stored,
    input  net_ctrl_pkg::tx_status_t  tx_status,
    input  net_ctrl_pkg::rx_status_t  rx_status,
    output net_ctrl_pkg::path_ctrl_t  ctrl,
    output logic                      msg_ready,
    output net_ctrl_pkg::tcp_state_e  tcp_state
);

    logic link_up;
    logic send_done;
    logic waiting;
    logic timed_out;

    // ------------------------------
    // level qualifiers
    // ------------------------------
    level_qualifier #(
        .HOLD_CYCLES (net_ctrl_pkg::LINK_WAIT)
    ) link_qual (
        .clk_PP   (clk_PP),
        .reset    (reset),
        .level_in (link_status),
        .level_ok (link_up)
    );

    // message ready goes straight out to the generator side
    level_qualifier #(
        .HOLD_CYCLES (net_ctrl_pkg::MSG_WAIT)
    ) msg_qual (
        .clk_PP   (clk_PP),
        .reset    (reset),
        .level_in (msg_stored),
        .level_ok (msg_ready)
    );

    // ------------------------------
    // control path
    // ------------------------------
    tcp_conn_fsm tcp_conn_fsm_inst (
        .clk_PP    (clk_PP),
        .reset     (reset),
        .link_up   (link_up),
        .rx_status (rx_status),
        .send_done (send_done),
        .tcp_state (tcp_state)
    );

    transfer_seq transfer_seq_inst (
        .clk_PP    (clk_PP),
        .reset     (reset),
        .tcp_state (tcp_state),
        .tx_status (tx_status),
        .rx_status (rx_status),
        .timed_out (timed_out),
        .ctrl      (ctrl),
        .send_done (send_done),
        .waiting   (waiting)
    );

    // times the WAIT_RX stay for the resend
    response_timer response_timer_inst (
        .clk_PP    (clk_PP),
        .reset     (reset),
        .waiting   (waiting),
        .timed_out (timed_out)
    );

endmodule

`default_nettype wire

// File: testbench/net_ctrl_asserts.sv
// concurrent checks on the generator/sniffer command bundle
// bound into the top level
`default_nettype none

module net_ctrl_asserts (
    input wire                       clk_PP,
    input wire                       reset,
    input net_ctrl_pkg::tx_status_t  tx_status,
    input net_ctrl_pkg::rx_status_t  rx_status,
    input net_ctrl_pkg::path_ctrl_t  ctrl
);

    // failed assertion count
    int fail_count = 0;

    // generator and sniffer never both held off
    block_exclusive: assert property (@(posedge clk_PP) disable iff (reset)
        !(ctrl.block_tx && ctrl.block_rx))
        else begin
            $error("block_tx and block_rx high together");
            fail_count++;
        end

    // a second strobe cycle only when SEND was not picked up by the generator
    strobe_single: assert property (@(posedge clk_PP) disable iff (reset)
        (ctrl.transfer_en && $past(ctrl.transfer_en)) |-> !$past(tx_status.busy, 2))
        else begin
            $error("transfer_en held although the generator took the frame");
            fail_count++;
        end

    // ack_received trails each valid frame by one cycle
    ack_follows: assert property (@(posedge clk_PP) disable iff (reset)
        rx_status.received_valid |=> ctrl.ack_received)
        else begin
            $error("ack_received missing after received_valid");
            fail_count++;
        end

    ack_only_after: assert property (@(posedge clk_PP) disable iff (reset)
        ctrl.ack_received |-> $past(rx_status.received_valid))
        else begin
            $error("ack_received without a received frame");
            fail_count++;
        end

endmodule

bind net_ctrl_top net_ctrl_asserts net_ctrl_asserts_inst (
    .clk_PP    (clk_PP),
    .reset     (reset),
    .tx_status (tx_status),
    .rx_status (rx_status),
    .ctrl      (ctrl)
);

`default_nettype wire

// File: testbench/net_ctrl_tb.sv
// testbench for the connection controller top level
// drives random generator/sniffer status from a fixed seed and checks
// tcp_state, ctrl and msg_ready against a cycle model on every clock
`default_nettype none

module net_ctrl_tb;

    logic                      clk_PP;
    logic                      reset;
    logic                      link_status;
    logic                      msg_stored;
    net_ctrl_pkg::tx_status_t  tx_status;
    net_ctrl_pkg::rx_status_t  rx_status;
    net_ctrl_pkg::path_ctrl_t  ctrl;
    logic                      msg_ready;
    net_ctrl_pkg::tcp_state_e  tcp_state;

    // values applied just after the next rising edge
    logic                      next_reset;
    logic                      next_link;
    logic                      next_msg;
    net_ctrl_pkg::tx_status_t  next_tx;
    net_ctrl_pkg::rx_status_t  next_rx;

    // cycle model state
    net_ctrl_pkg::tcp_state_e  m_tcp;
    net_ctrl_pkg::xfer_state_e m_xfer;
    logic                      m_ten;
    logic                      m_ack;
    logic                      m_link_ok;
    logic                      m_msg_ok;
    int                        m_link_cnt;
    int                        m_msg_cnt;
    int                        m_lost;

    int                        errors;
    int                        tests_run;
    int                        tests_failed;
    int                        test_err_start;
    bit                        hung;
    bit                        seen_ack;
    int                        n;

    net_ctrl_top net_ctrl_top_inst (
        .clk_PP      (clk_PP),
        .reset       (reset),
        .link_status (link_status),
        .msg_stored  (msg_stored),
        .tx_status   (tx_status),
        .rx_status   (rx_status),
        .ctrl        (ctrl),
        .msg_ready   (msg_ready),
        .tcp_state   (tcp_state)
    );

    initial begin
        clk_PP = 1'b0;
        forever #5 clk_PP = ~clk_PP;
    end

    // ------------------------------
    // cycle model
    // ------------------------------
    task automatic model_reset();
        m_tcp      = net_ctrl_pkg::DISCONNECT;
        m_xfer     = net_ctrl_pkg::IDLE;
        m_ten      = 1'b0;
        m_ack      = 1'b0;
        m_link_ok  = 1'b0;
        m_msg_ok   = 1'b0;
        m_link_cnt = 0;
        m_msg_cnt  = 0;
        m_lost     = 0;
    endtask

    // one clock edge, inputs as sampled at that edge
    task automatic model_step();
        net_ctrl_pkg::tcp_state_e  t_n;
        net_ctrl_pkg::xfer_state_e x_n;
        logic                      sdone;
        logic                      tout;
        logic                      replies;
        logic                      frame;
        if (reset) begin
            model_reset();
            return;
        end
        sdone   = (m_xfer == net_ctrl_pkg::WAIT_TX) && !tx_status.busy;
        tout    = (m_lost == net_ctrl_pkg::LOST_LIMIT);
        frame   = rx_status.received_valid;
        // syn and data frames wait for an answer
        replies = (m_tcp == net_ctrl_pkg::HANDSHAKE_SYN) || (m_tcp == net_ctrl_pkg::TRANSFER);
        t_n = m_tcp;
        case (m_tcp)
            net_ctrl_pkg::DISCONNECT:
                if (m_link_ok) t_n = net_ctrl_pkg::HANDSHAKE_SYN;
            net_ctrl_pkg::HANDSHAKE_SYN:
                if (frame && rx_status.is_handshake) t_n = net_ctrl_pkg::HANDSHAKE_ACK;
            net_ctrl_pkg::HANDSHAKE_ACK, net_ctrl_pkg::ACK_SEND:
                if (sdone) t_n = net_ctrl_pkg::TRANSFER;
            net_ctrl_pkg::TRANSFER:
                if (frame && rx_status.is_handshake) t_n = net_ctrl_pkg::HANDSHAKE_ACK;
                else if (frame && rx_status.need_ack) t_n = net_ctrl_pkg::ACK_SEND;
            default: ;
        endcase
        x_n = m_xfer;
        if (m_tcp == net_ctrl_pkg::DISCONNECT) begin
            x_n = net_ctrl_pkg::IDLE;
        end else begin
            case (m_xfer)
                net_ctrl_pkg::IDLE:
                    if (!tx_status.busy && (m_tcp != net_ctrl_pkg::TRANSFER ||
                                            tx_status.msg_pending))
                        x_n = net_ctrl_pkg::SEND;
                net_ctrl_pkg::SEND:
                    if (m_tcp == net_ctrl_pkg::TRANSFER && !tx_status.msg_pending)
                        x_n = net_ctrl_pkg::IDLE;
                    else if (tx_status.busy)
                        x_n = net_ctrl_pkg::WAIT_TX;
                net_ctrl_pkg::WAIT_TX:
                    if (!tx_status.busy)
                        x_n = replies ? net_ctrl_pkg::WAIT_RX : net_ctrl_pkg::IDLE;
                net_ctrl_pkg::WAIT_RX:
                    if (rx_status.busy) x_n = net_ctrl_pkg::WAIT_ACK_CHECK;
                    else if (tout) x_n = net_ctrl_pkg::SEND;
                net_ctrl_pkg::WAIT_ACK_CHECK:
                    if (frame && !rx_status.is_handshake && !rx_status.need_ack &&
                        tx_status.msg_pending)
                        x_n = net_ctrl_pkg::WAIT_TX_ACK;
                    else if (frame)
                        x_n = net_ctrl_pkg::WAIT_RX_LAST;
                    else if (!rx_status.busy)
                        x_n = net_ctrl_pkg::IDLE;
                net_ctrl_pkg::WAIT_TX_ACK:
                    if (tx_status.ack_taken) x_n = net_ctrl_pkg::WAIT_RX_LAST;
                net_ctrl_pkg::WAIT_RX_LAST:
                    if (!rx_status.busy) x_n = net_ctrl_pkg::IDLE;
                default: ;
            endcase
        end
        // qualifier outputs lag their counters by one edge
        m_link_ok  = (m_link_cnt == net_ctrl_pkg::LINK_WAIT);
        m_msg_ok   = (m_msg_cnt == net_ctrl_pkg::MSG_WAIT);
        m_link_cnt = !link_status ? 0 :
                     (m_link_cnt == net_ctrl_pkg::LINK_WAIT) ? m_link_cnt : m_link_cnt + 1;
        m_msg_cnt  = !msg_stored ? 0 :
                     (m_msg_cnt == net_ctrl_pkg::MSG_WAIT) ? m_msg_cnt : m_msg_cnt + 1;
        m_lost     = (m_xfer != net_ctrl_pkg::WAIT_RX) ? 0 : tout ? m_lost : m_lost + 1;
        m_ten      = (m_xfer == net_ctrl_pkg::SEND);
        m_ack      = frame;
        m_tcp      = t_n;
        m_xfer     = x_n;
    endtask

    task automatic check_outputs();
        net_ctrl_pkg::path_ctrl_t exp_ctrl;
        exp_ctrl.transfer_en  = m_ten;
        exp_ctrl.block_tx     = m_xfer inside {net_ctrl_pkg::IDLE, net_ctrl_pkg::WAIT_RX,
                                               net_ctrl_pkg::WAIT_RX_LAST};
        exp_ctrl.block_rx     = m_xfer inside {net_ctrl_pkg::SEND, net_ctrl_pkg::WAIT_TX};
        exp_ctrl.ack_received = m_ack;
        if (tcp_state !== m_tcp) begin
            $display("Error at %0t: tcp_state is %s, expected %s",
                     $time, tcp_state.name(), m_tcp.name());
            errors++;
        end
        if (ctrl !== exp_ctrl) begin
            $display("Error at %0t: ctrl is %b, expected %b (xfer %s)",
                     $time, ctrl, exp_ctrl, m_xfer.name());
            errors++;
        end
        if (msg_ready !== m_msg_ok) begin
            $display("Error at %0t: msg_ready is %b, expected %b", $time, msg_ready, m_msg_ok);
            errors++;
        end
    endtask

    // ------------------------------
    // stimulus helpers
    // ------------------------------
    // edge, model, drive 1 unit later, check once settled
    task automatic cycle();
        @(posedge clk_PP);
        model_step();
        #1;
        reset       = next_reset;
        link_status = next_link;
        msg_stored  = next_msg;
        tx_status   = next_tx;
        rx_status   = next_rx;
        if (reset)
            model_reset();
        #3;
        check_outputs();
    endtask

    task automatic drive_random(input bit force_hs);
        next_tx.busy              = ($urandom % 2) == 0;
        next_tx.msg_pending       = ($urandom % 4) != 0;
        next_tx.ack_taken         = ($urandom % 4) == 0;
        next_rx.busy              = ($urandom % 2) == 0;
        next_rx.received_valid    = ($urandom % 8) == 0;
        next_rx.is_handshake      = force_hs || (($urandom % 8) == 0);
        next_rx.need_ack          = ($urandom % 4) == 0;
        // slow toggling so msg_stored sometimes qualifies
        if (($urandom % 32) == 0)
            next_msg = !next_msg;
    endtask

    task automatic start_test();
        test_err_start = errors;
    endtask

    task automatic end_test(input string name);
        tests_run++;
        if (errors == test_err_start && !hung) begin
            $display("test %s: passed", name);
        end else begin
            tests_failed++;
            $display("test %s: failed with %0d errors", name, errors - test_err_start);
        end
    endtask

    task automatic note_timeout(input string what);
        hung = 1'b1;
        $display("timeout at %0t: %s did not happen within 500 cycles", $time, what);
    endtask

    // ------------------------------
    // test sequence
    // ------------------------------
    initial begin
        void'($urandom(32'h569e));
        reset       = 1'b1;
        link_status = 1'b0;
        msg_stored  = 1'b0;
        tx_status   = '0;
        rx_status   = '0;
        next_reset  = 1'b1;
        next_link   = 1'b0;
        next_msg    = 1'b0;
        next_tx     = '0;
        next_rx     = '0;
        errors      = 0;
        tests_run   = 0;
        tests_failed = 0;
        hung        = 1'b0;
        model_reset();
        repeat (8) cycle();
        next_reset = 1'b0;

        // short link pulses, then a held level
        start_test();
        repeat (3) begin
            next_link = 1'b1;
            repeat (net_ctrl_pkg::LINK_WAIT - 4) cycle();
            next_link = 1'b0;
            repeat (3) cycle();
        end
        if (tcp_state !== net_ctrl_pkg::DISCONNECT) begin
            $display("Error at %0t: short link pulses left DISCONNECT", $time);
            errors++;
        end
        next_link = 1'b1;
        cycle();
        n = 0;
        while (tcp_state !== net_ctrl_pkg::HANDSHAKE_SYN && n < 500) begin
            cycle();
            n++;
        end
        if (tcp_state !== net_ctrl_pkg::HANDSHAKE_SYN)
            note_timeout("link bring-up");
        else if (n != net_ctrl_pkg::LINK_WAIT + 2) begin
            $display("Error at %0t: link up after %0d edges, expected %0d",
                     $time, n, net_ctrl_pkg::LINK_WAIT + 2);
            errors++;
        end
        end_test("link bring-up");

        // msg_stored qualification and release
        if (!hung) begin
            start_test();
            next_msg = 1'b1;
            cycle();
            n = 0;
            while (msg_ready !== 1'b1 && n < 500) begin
                cycle();
                n++;
            end
            if (msg_ready !== 1'b1)
                note_timeout("msg_ready rise");
            else if (n != net_ctrl_pkg::MSG_WAIT + 1) begin
                $display("Error at %0t: msg_ready rose after %0d edges, expected %0d",
                         $time, n, net_ctrl_pkg::MSG_WAIT + 1);
                errors++;
            end
            next_msg = 1'b0;
            cycle();
            n = 0;
            while (msg_ready !== 1'b0 && n < 500) begin
                cycle();
                n++;
            end
            if (msg_ready !== 1'b0)
                note_timeout("msg_ready fall");
            else if (n != 2) begin
                $display("Error at %0t: msg_ready fell after %0d edges, expected 2", $time, n);
                errors++;
            end
            end_test("message qualification");
        end

        // syn goes out, sniffer stays silent, resend after the timeout
        if (!hung) begin
            start_test();
            n = 0;
            while (m_xfer != net_ctrl_pkg::WAIT_RX && n < 500) begin
                next_tx.busy = (m_xfer == net_ctrl_pkg::SEND);
                cycle();
                n++;
            end
            next_tx = '0;
            if (m_xfer != net_ctrl_pkg::WAIT_RX)
                note_timeout("entry to WAIT_RX");
            n = 0;
            while (!hung && ctrl.transfer_en !== 1'b1 && n < 500) begin
                cycle();
                n++;
            end
            if (!hung && ctrl.transfer_en !== 1'b1)
                note_timeout("resend strobe");
            else if (!hung && n != net_ctrl_pkg::LOST_LIMIT + 2) begin
                $display("Error at %0t: resend after %0d edges, expected %0d",
                         $time, n, net_ctrl_pkg::LOST_LIMIT + 2);
                errors++;
            end
            end_test("timeout resend");
        end

        // random busy timing, only handshake frames from the peer
        if (!hung) begin
            start_test();
            seen_ack = 1'b0;
            n = 0;
            while (tcp_state !== net_ctrl_pkg::TRANSFER && n < 500) begin
                drive_random(1'b1);
                cycle();
                if (tcp_state === net_ctrl_pkg::HANDSHAKE_ACK)
                    seen_ack = 1'b1;
                n++;
            end
            if (tcp_state !== net_ctrl_pkg::TRANSFER)
                note_timeout("handshake completion");
            else if (!seen_ack) begin
                $display("Error at %0t: TRANSFER reached without HANDSHAKE_ACK", $time);
                errors++;
            end
            end_test("handshake");
        end

        for (int t = 0; t < 10; t++) begin
            if (!hung) begin
                start_test();
                repeat (200) begin
                    drive_random(1'b0);
                    cycle();
                end
                end_test($sformatf("random %0d", t));
            end
        end

        // reset in the middle of traffic
        if (!hung) begin
            start_test();
            next_tx    = '0;
            next_rx    = '0;
            next_reset = 1'b1;
            repeat (8) cycle();
            if (tcp_state !== net_ctrl_pkg::DISCONNECT || ctrl !== 4'b0100 ||
                msg_ready !== 1'b0) begin
                $display("Error at %0t: outputs not at reset values (%s %b %b)",
                         $time, tcp_state.name(), ctrl, msg_ready);
                errors++;
            end
            next_reset = 1'b0;
            repeat (60) begin
                drive_random(1'b0);
                cycle();
            end
            end_test("mid-run reset");
        end

        $display("summary: %0d tests run, %0d failed, %0d check errors, %0d assertion failures",
                 tests_run, tests_failed, errors,
                 net_ctrl_top_inst.net_ctrl_asserts_inst.fail_count);
        if (errors == 0 && !hung &&
            net_ctrl_top_inst.net_ctrl_asserts_inst.fail_count == 0) begin
            $display("RESULT: PASS");
        end else begin
            $display("RESULT: FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: net_ctrl.f
source/net_ctrl_pkg.sv
source/level_qualifier.sv
source/tcp_conn_fsm.sv
source/transfer_seq.sv
source/response_timer.sv
source/net_ctrl_top.sv
testbench/net_ctrl_asserts.sv
testbench/net_ctrl_tb.sv

// File: Makefile
VERILATOR ?= verilator
TOP       ?= net_ctrl_tb
FILELIST  ?= net_ctrl.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: compile
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@if grep -q "RESULT: FAIL" $(LOG); then echo "simulation failed"; exit 1; fi
	@if ! grep -q "RESULT: PASS" $(LOG); then echo "simulation did not finish"; exit 1; fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)
